// File: include/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// bus widths
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 32
`define AXI_RESP_WIDTH 2

// direct mapped, one word per line
`define ICACHE_OFFSET_BITS 2
`define ICACHE_INDEX_BITS 4

`define RESET_PC 32'h0000_1000
`define INST_BUF_DEPTH 4  // power of two

`endif

// File: source/fetch_pkg.sv
`include "fetch_settings.svh"

package fetch_pkg;

    typedef logic [`AXI_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`AXI_DATA_WIDTH-1:0] data_t;
    typedef logic [`AXI_RESP_WIDTH-1:0] resp_t;  // zero is OKAY

    // one fetched instruction on its way to decode
    typedef struct packed {
        addr_t pc;
        data_t inst;
        logic  fault;
    } fetch_entry_t;

endpackage

// File: source/pc_sequencer.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module pc_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    redirect,
    input  fetch_pkg::addr_t        redirect_pc,
    output fetch_pkg::addr_t        core_araddr,
    output logic                    core_arvalid,
    input  logic                    core_arready,
    input  fetch_pkg::data_t        core_rdata,
    input  fetch_pkg::resp_t        core_rresp,
    input  logic                    core_rvalid,
    output logic                    core_rready,
    output logic                    push,
    output fetch_pkg::fetch_entry_t push_entry,
    input  logic                    full
);
    import fetch_pkg::*;

    addr_t pc;          // next fetch address
    addr_t ar_addr;
    addr_t fetch_pc;    // pc of the accepted fetch
    logic  ar_pending;
    logic  outstanding;
    logic  stale;       // in-flight request belongs to the old path
    logic  issue;
    logic  ar_fire;
    logic  r_fire;

    assign ar_fire = core_arvalid && core_arready;
    assign r_fire  = core_rvalid && core_rready;
    assign issue   = !ar_pending && !outstanding && !redirect;

    assign core_araddr  = ar_addr;
    assign core_arvalid = ar_pending;
    assign core_rready  = !full;

    assign push       = r_fire && !stale && !redirect;
    assign push_entry = '{pc: fetch_pc, inst: core_rdata, fault: (core_rresp != '0)};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= `RESET_PC;
            ar_pending  <= 1'b0;
            outstanding <= 1'b0;
            stale       <= 1'b0;
        end else begin
            if (redirect) begin
                pc <= redirect_pc;
            end else if (ar_fire && !stale) begin
                pc <= pc + addr_t'(4);
            end

            if (issue) begin
                ar_pending <= 1'b1;
            end else if (ar_fire) begin
                ar_pending <= 1'b0;
            end

            if (ar_fire) begin
                outstanding <= 1'b1;
            end else if (r_fire) begin
                outstanding <= 1'b0;
            end

            // a response returning this cycle is simply not pushed
            if (redirect && (ar_pending || (outstanding && !r_fire))) begin
                stale <= 1'b1;
            end else if (r_fire) begin
                stale <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            ar_addr <= pc;
        end
        if (ar_fire) begin
            fetch_pc <= ar_addr;
        end
    end

    a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        core_arvalid && !core_arready |=> core_arvalid && $stable(core_araddr))
        else $error("fetch address changed while AR pending");

    a_ar_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        core_arvalid |-> core_araddr[1:0] == 2'b00)
        else $error("fetch address not word aligned");

    a_resp_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        core_rvalid |-> outstanding)
        else $error("response without an outstanding fetch");

endmodule

// File: source/icache.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module icache (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cache_flush,
    input  fetch_pkg::addr_t core_araddr,
    input  logic             core_arvalid,
    output logic             core_arready,
    output fetch_pkg::data_t core_rdata,
    output fetch_pkg::resp_t core_rresp,
    output logic             core_rvalid,
    input  logic             core_rready,
    output fetch_pkg::addr_t mem_araddr,
    output logic             mem_arvalid,
    input  logic             mem_arready,
    input  fetch_pkg::data_t mem_rdata,
    input  fetch_pkg::resp_t mem_rresp,
    input  logic             mem_rvalid,
    output logic             mem_rready
);
    import fetch_pkg::*;

    localparam int OFFSET_W = `ICACHE_OFFSET_BITS;
    localparam int INDEX_W  = `ICACHE_INDEX_BITS;
    localparam int TAG_W    = `AXI_ADDR_WIDTH - OFFSET_W - INDEX_W;
    localparam int LINES    = 2 ** INDEX_W;

    typedef enum logic [1:0] {REQ_IDLE, REQ_LOOKUP, REQ_MISS, REQ_RETURN} req_state_t;
    typedef enum logic [1:0] {FILL_IDLE, FILL_ADDR, FILL_WAIT, FILL_DONE} fill_state_t;

    req_state_t  req_state;
    fill_state_t fill_state;

    data_t            data_array [LINES];
    logic [TAG_W-1:0] tag_array  [LINES];
    logic [LINES-1:0] valid_array;

    addr_t req_addr;
    data_t ret_data;
    resp_t ret_resp;
    data_t fill_data;
    resp_t fill_resp;
    logic  flush_pending;

    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag;
    logic               hit;
    logic               ar_fire;
    logic               fill_ok;
    logic               flush_apply;

    assign index   = req_addr[OFFSET_W +: INDEX_W];
    assign tag     = req_addr[`AXI_ADDR_WIDTH-1 -: TAG_W];
    assign hit     = valid_array[index] && (tag_array[index] == tag);
    assign ar_fire = core_arvalid && core_arready;
    assign fill_ok = (fill_state == FILL_DONE) && (fill_resp == '0);

    // flush waits for a quiet idle cycle
    assign flush_apply = flush_pending && (req_state == REQ_IDLE) && !ar_fire;

    assign core_arready = (req_state == REQ_IDLE);
    assign core_rvalid  = (req_state == REQ_RETURN);
    assign core_rdata   = ret_data;
    assign core_rresp   = ret_resp;
    assign mem_araddr   = req_addr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_state <= REQ_IDLE;
        end else begin
            case (req_state)
                REQ_IDLE: if (ar_fire) req_state <= REQ_LOOKUP;
                REQ_LOOKUP: req_state <= hit ? REQ_RETURN : REQ_MISS;
                REQ_MISS: if (fill_state == FILL_DONE) req_state <= REQ_RETURN;
                REQ_RETURN: if (core_rready) req_state <= REQ_IDLE;
                default: req_state <= REQ_IDLE;
            endcase
        end
    end

    // refill side, one word per miss
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill_state  <= FILL_IDLE;
            mem_arvalid <= 1'b0;
            mem_rready  <= 1'b0;
        end else begin
            case (fill_state)
                FILL_IDLE: begin
                    if (req_state == REQ_LOOKUP && !hit) begin
                        fill_state  <= FILL_ADDR;
                        mem_arvalid <= 1'b1;
                    end
                end
                FILL_ADDR: begin
                    if (mem_arready) begin
                        fill_state  <= FILL_WAIT;
                        mem_arvalid <= 1'b0;
                        mem_rready  <= 1'b1;
                    end
                end
                FILL_WAIT: begin
                    if (mem_rvalid) begin
                        fill_state <= FILL_DONE;
                        mem_rready <= 1'b0;
                    end
                end
                default: fill_state <= FILL_IDLE;  // FILL_DONE
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            req_addr <= core_araddr;
        end
        if (fill_state == FILL_WAIT && mem_rvalid) begin
            fill_data <= mem_rdata;
            fill_resp <= mem_rresp;
        end
        if (req_state == REQ_LOOKUP && hit) begin
            ret_data <= data_array[index];
            ret_resp <= '0;
        end else if (req_state == REQ_MISS && fill_state == FILL_DONE) begin
            ret_data <= fill_data;  // error code passes through as is
            ret_resp <= fill_resp;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_array   <= '0;
            flush_pending <= 1'b0;
        end else begin
            if (cache_flush) begin
                flush_pending <= 1'b1;
            end else if (flush_apply) begin
                flush_pending <= 1'b0;
            end
            if (flush_apply) begin
                valid_array <= '0;
            end else if (fill_ok) begin
                valid_array[index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_ok) begin
            data_array[index] <= fill_data;
            tag_array[index]  <= tag;
        end
    end

    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        core_rvalid && !core_rready |=> core_rvalid && $stable(core_rdata))
        else $error("core_rvalid dropped before core_rready");

    a_arvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr))
        else $error("mem_arvalid dropped before mem_arready");

endmodule

// File: source/inst_buffer.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module inst_buffer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    redirect,
    input  logic                    push,
    input  fetch_pkg::fetch_entry_t push_entry,
    output logic                    full,
    output logic                    inst_valid,
    input  logic                    inst_ready,
    output fetch_pkg::addr_t        inst_pc,
    output fetch_pkg::data_t        inst_data,
    output logic                    inst_fault
);
    import fetch_pkg::*;

    localparam int DEPTH = `INST_BUF_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    fetch_entry_t     mem [DEPTH];
    fetch_entry_t     head;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             pop;

    assign full       = (count == (PTR_W+1)'(DEPTH));
    assign inst_valid = (count != '0);
    assign pop        = inst_valid && inst_ready;

    assign head       = mem[rd_ptr];
    assign inst_pc    = head.pc;
    assign inst_data  = head.inst;
    assign inst_fault = head.fault;

    always_ff @(posedge clk) begin
        if (!rst_n || redirect) begin  // redirect drops the old path
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
        count <= (PTR_W+1)'(DEPTH))
        else $error("buffer count above depth");

endmodule

// File: source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             redirect,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             cache_flush,
    output logic             inst_valid,
    input  logic             inst_ready,
    output fetch_pkg::addr_t inst_pc,
    output fetch_pkg::data_t inst_data,
    output logic             inst_fault,
    output fetch_pkg::addr_t mem_araddr,
    output logic             mem_arvalid,
    input  logic             mem_arready,
    input  fetch_pkg::data_t mem_rdata,
    input  fetch_pkg::resp_t mem_rresp,
    input  logic             mem_rvalid,
    output logic             mem_rready
);
    import fetch_pkg::*;

    // core side read channel
    addr_t core_araddr;
    logic  core_arvalid;
    logic  core_arready;
    data_t core_rdata;
    resp_t core_rresp;
    logic  core_rvalid;
    logic  core_rready;

    fetch_entry_t push_entry;
    logic         push;
    logic         full;

    pc_sequencer i_pc_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .core_araddr  (core_araddr),
        .core_arvalid (core_arvalid),
        .core_arready (core_arready),
        .core_rdata   (core_rdata),
        .core_rresp   (core_rresp),
        .core_rvalid  (core_rvalid),
        .core_rready  (core_rready),
        .push         (push),
        .push_entry   (push_entry),
        .full         (full)
    );

    icache i_icache (
        .clk          (clk),
        .rst_n        (rst_n),
        .cache_flush  (cache_flush),
        .core_araddr  (core_araddr),
        .core_arvalid (core_arvalid),
        .core_arready (core_arready),
        .core_rdata   (core_rdata),
        .core_rresp   (core_rresp),
        .core_rvalid  (core_rvalid),
        .core_rready  (core_rready),
        .mem_araddr   (mem_araddr),
        .mem_arvalid  (mem_arvalid),
        .mem_arready  (mem_arready),
        .mem_rdata    (mem_rdata),
        .mem_rresp    (mem_rresp),
        .mem_rvalid   (mem_rvalid),
        .mem_rready   (mem_rready)
    );

    inst_buffer i_inst_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .redirect   (redirect),
        .push       (push),
        .push_entry (push_entry),
        .full       (full),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .inst_pc    (inst_pc),
        .inst_data  (inst_data),
        .inst_fault (inst_fault)
    );

endmodule

// File: testbench/tb_fetch_unit.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module tb_fetch_unit;
    import fetch_pkg::*;

    localparam data_t WORD_KEY       = 32'h5A5A_C3C3;
    localparam addr_t ERR_LO         = 32'h0000_7000;  // SLVERR window
    localparam addr_t ERR_HI         = 32'h0000_7100;
    localparam int    TIMEOUT_CYCLES = 4000;  // roughly 3x the whole run

    logic  clk;
    logic  rst_n;
    logic  redirect;
    addr_t redirect_pc;
    logic  cache_flush;
    logic  inst_valid;
    logic  inst_ready;
    addr_t inst_pc;
    data_t inst_data;
    logic  inst_fault;
    addr_t mem_araddr;
    logic  mem_arvalid;
    logic  mem_arready;
    data_t mem_rdata;
    resp_t mem_rresp;
    logic  mem_rvalid;
    logic  mem_rready;

    addr_t ar_log[$];  // every bus AR address in order
    addr_t rd_addr;
    int    ar_wait;
    int    r_wait;
    bit    r_busy;
    int    cycles = 0;

    fetch_unit i_fetch_unit (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: no instruction stream finished within %0d cycles", cycles);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    function automatic data_t mem_word(input addr_t a);
        return {a[15:0], a[31:16]} ^ WORD_KEY;
    endfunction

    function automatic bit in_err_window(input addr_t a);
        return (a >= ERR_LO) && (a < ERR_HI);
    endfunction

    function automatic int count_bus_ars(input addr_t a);
        int n;
        n = 0;
        foreach (ar_log[i]) begin
            if (ar_log[i] == a) n++;
        end
        return n;
    endfunction

    // memory model with one read at a time and random stalls
    always @(posedge clk) begin
        if (!rst_n) begin
            mem_arready <= 1'b0;
            mem_rvalid  <= 1'b0;
            r_busy = 1'b0;
            ar_wait = $urandom % 4;
        end else begin
            if (mem_rvalid && mem_rready) begin
                mem_rvalid <= 1'b0;
                r_busy = 1'b0;
            end else if (r_busy && !mem_rvalid && mem_rready) begin
                if (r_wait == 0) begin
                    mem_rvalid <= 1'b1;
                    mem_rdata  <= in_err_window(rd_addr) ? '0 : mem_word(rd_addr);
                    mem_rresp  <= in_err_window(rd_addr) ? resp_t'(2) : resp_t'(0);
                end else begin
                    r_wait--;
                end
            end
            if (mem_arvalid && mem_arready) begin
                mem_arready <= 1'b0;
                ar_log.push_back(mem_araddr);
                rd_addr = mem_araddr;
                r_busy  = 1'b1;
                r_wait  = $urandom % 4;
                ar_wait = $urandom % 4;
            end else if (mem_arvalid && !r_busy) begin
                if (ar_wait == 0) mem_arready <= 1'b1;
                else ar_wait--;
            end
        end
    end

    task automatic compare_value(input logic [63:0] got, input logic [63:0] exp,
                                 input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            $display("sim failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // take n instructions with pc stepping by 4 from start
    task automatic consume_run(input addr_t start, input int n, input bit jitter);
        addr_t pc;
        int    got;
        pc  = start;
        got = 0;
        inst_ready <= jitter ? 1'($urandom % 2) : 1'b1;
        while (got < n) begin
            @(posedge clk);
            if (inst_valid && inst_ready) begin
                compare_value(inst_pc, pc, "inst_pc");
                compare_value(inst_fault, in_err_window(pc), "inst_fault");
                if (!in_err_window(pc)) begin
                    compare_value(inst_data, mem_word(pc), "inst_data");
                end
                pc  = pc + 32'd4;
                got = got + 1;
            end
            if (got == n) begin
                inst_ready <= 1'b0;  // stop exactly after n
            end else if (jitter) begin
                inst_ready <= 1'($urandom % 2);
            end
        end
    endtask

    task automatic audit_bus_ars(input addr_t start, input int n, input int exp);
        @(negedge clk);  // log is stable here
        for (int i = 0; i < n; i++) begin
            compare_value(count_bus_ars(start + addr_t'(4 * i)), exp, "bus AR count");
        end
    endtask

    task automatic send_redirect(input addr_t pc);
        @(posedge clk);
        redirect    <= 1'b1;
        redirect_pc <= pc;
        @(posedge clk);
        redirect <= 1'b0;
    endtask

    task automatic flush_cache();
        @(posedge clk);
        cache_flush <= 1'b1;
        @(posedge clk);
        cache_flush <= 1'b0;
    endtask

    task automatic sequential_fetch();
        consume_run(`RESET_PC, 8, 1'b0);
        audit_bus_ars(`RESET_PC, 8, 1);
    endtask

    task automatic hits_and_flush();
        send_redirect(`RESET_PC);
        consume_run(`RESET_PC, 8, 1'b0);
        audit_bus_ars(`RESET_PC, 8, 1);  // all hits
        flush_cache();
        send_redirect(`RESET_PC);
        consume_run(`RESET_PC, 8, 1'b0);
        audit_bus_ars(`RESET_PC, 8, 2);
    endtask

    task automatic conflict_eviction();
        addr_t target;
        for (int k = 0; k < 6; k++) begin
            target = (k % 2 == 1) ? 32'h0000_2040 : 32'h0000_2000;  // same index
            send_redirect(target);
            consume_run(target, 1, 1'b0);
            audit_bus_ars(target, 1, k / 2 + 1);
        end
    endtask

    task automatic redirect_during_miss();
        send_redirect(32'h0000_4000);
        consume_run(32'h0000_4000, 2, 1'b0);
        do @(posedge clk); while (!mem_arvalid);  // prefetch miss under way
        redirect    <= 1'b1;
        redirect_pc <= 32'h0000_5000;
        @(posedge clk);
        redirect <= 1'b0;
        consume_run(32'h0000_5000, 4, 1'b0);
    endtask

    task automatic back_pressure();
        send_redirect(32'h0000_6000);
        consume_run(32'h0000_6000, 12, 1'b0);  // warm the lines first
        send_redirect(32'h0000_6000);
        inst_ready <= 1'b0;
        do @(posedge clk); while (!inst_valid);
        repeat (30) @(posedge clk);  // hits fill the buffer meanwhile
        consume_run(32'h0000_6000, 12, 1'b1);
        audit_bus_ars(32'h0000_6000, 12, 1);
    endtask

    task automatic bus_error_refetch();
        for (int k = 1; k <= 2; k++) begin
            send_redirect(ERR_LO);
            consume_run(ERR_LO, 1, 1'b0);
            audit_bus_ars(ERR_LO, 1, k);  // never filled, so always a miss
        end
    endtask

    initial begin
        void'($urandom(27));
        rst_n       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        cache_flush = 1'b0;
        inst_ready  = 1'b0;
        mem_arready = 1'b0;
        mem_rdata   = '0;
        mem_rresp   = '0;
        mem_rvalid  = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        sequential_fetch();
        hits_and_flush();
        conflict_eviction();
        redirect_during_miss();
        back_pressure();
        bus_error_refetch();

        $display("sim passed");
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
source/fetch_pkg.sv
source/pc_sequencer.sv
source/icache.sv
source/inst_buffer.sv
source/fetch_unit.sv
testbench/tb_fetch_unit.sv
